/* verif/ooo_core_tests.mem */
// first value: instruction count; then one instruction per line
// columns: instruction word, expected commit rd (ff = no commit), expected commit value
25        // instruction count
00500093 01 00000005  // addi x1, x0, 5
FFD00113 02 FFFFFFFD  // addi x2, x0, -3
00112193 03 00000001  // slti x3, x2, 1
FFF0C213 04 FFFFFFFA  // xori x4, x1, -1
7F006293 05 000007F0  // ori  x5, x0, 0x7f0
0FF27313 06 000000FA  // andi x6, x4, 0xff
402083B3 07 00000008  // sub  x7, x1, x2
00112433 08 00000001  // slt  x8, x2, x1
006094B3 09 14000000  // sll  x9, x1, x6
00125533 0A 07FFFFFF  // srl  x10, x4, x1
0072C5B3 0B 000007F8  // xor  x11, x5, x7
0091E633 0C 14000001  // or   x12, x3, x9
0065F6B3 0D 000000F8  // and  x13, x11, x6
00768733 0E 00000100  // add  x14, x13, x7
00E70733 0E 00000200  // add  x14, x14, x14
FFF70713 0E 000001FF  // addi x14, x14, -1
02E107B3 0F FFFFFA03  // mul  x15, x2, x14
00108833 10 0000000A  // add  x16, x1, x1
06400893 11 00000064  // addi x17, x0, 100
01078933 12 FFFFFA0D  // add  x18, x15, x16
00708013 00 0000000C  // addi x0, x1, 7
123452B7 FF 00000000  // lui  x5, 0x12345 (dropped)
4020D2B3 FF 00000000  // sra  x5, x1, x2 (dropped)
005009B3 13 000007F0  // add  x19, x0, x5
00000A33 14 00000000  // add  x20, x0, x0
00300A93 15 00000003  // addi x21, x0, 3
00300B13 16 00000003  // addi x22, x0, 3
036A8AB3 15 00000009  // mul  x21, x21, x22
036A8AB3 15 0000001B  // mul  x21, x21, x22
036A8AB3 15 00000051  // mul  x21, x21, x22
036A8AB3 15 000000F3  // mul  x21, x21, x22
036A8AB3 15 000002D9  // mul  x21, x21, x22
036A8AB3 15 0000088B  // mul  x21, x21, x22
036A8AB3 15 000019A1  // mul  x21, x21, x22
036A8AB3 15 00004CE3  // mul  x21, x21, x22
022A8BB3 17 FFFF1957  // mul  x23, x21, x2
015B8C33 18 FFFF663A  // add  x24, x23, x21

/* ooo_core.f */
hw/ooo_pkg.sv
hw/issue_if.sv
hw/inst_queue.sv
hw/issue_unit.sv
hw/register_file.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/execute_stage.sv
hw/ooo_core.sv
verif/ooo_core_sva.sv
verif/ooo_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
SEED      ?= 92
FILELIST  ?= ooo_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100

SIM      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
TESTS    := verif/ooo_core_tests.mem
PASS_MSG := Simulation finished: PASS

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TESTS)
	./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG); grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/ooo_core_tb.sv */
`timescale 1ns/10ps

module commit_checker (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        exp_push,
  input  int          exp_index,
  input  logic [4:0]  exp_rd,
  input  logic [31:0] exp_value,
  input  logic        commit_valid,
  input  logic [4:0]  commit_rd,
  input  logic [31:0] commit_value,
  output int          error_count,
  output int          pending,
  output int          commit_count
);
  int          index_q [$];  // program order of outstanding commits
  logic [4:0]  rd_q [$];
  logic [31:0] value_q [$];
  int          cur_index;
  logic [4:0]  cur_rd;
  logic [31:0] cur_value;

  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      error_count  = 0;
      commit_count = 0;
      index_q.delete();
      rd_q.delete();
      value_q.delete();
    end else begin
      if (commit_valid) begin
        commit_count++;
        if (index_q.size() == 0) begin
          error_count++;
          $display("commit to x%0d value %h with no instruction outstanding",
                   commit_rd, commit_value);
        end else begin
          cur_index = index_q.pop_front();
          cur_rd    = rd_q.pop_front();
          cur_value = value_q.pop_front();
          if (commit_rd !== cur_rd) begin
            error_count++;
            $display("[FAIL] inst_%0d rd: expected %0d, actual %0d",
                     cur_index, cur_rd, commit_rd);
          end
          if (commit_value !== cur_value) begin
            error_count++;
            $display("[FAIL] inst_%0d value: expected %h, actual %h",
                     cur_index, cur_value, commit_value);
          end
        end
      end
      if (exp_push) begin
        index_q.push_back(exp_index);
        rd_q.push_back(exp_rd);
        value_q.push_back(exp_value);
      end
    end
    pending = index_q.size();
  end
endmodule

module ooo_core_tb #(
  parameter int SEED = 92
);
  localparam int          max_tests = 64;
  localparam logic [31:0] no_commit = 32'h0000_00ff;  // rd marker of a NOP entry

  logic        clk_100mhz;
  logic        sys_rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic        inst_ready;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [31:0] commit_value;
  logic        exp_push;
  int          exp_index;
  logic [4:0]  exp_rd;
  logic [31:0] exp_value;
  int          checker_errors;
  int          pending;
  int          commit_count;
  logic [31:0] test_mem [1 + 3 * max_tests];
  int          n_tests;
  int          tb_errors;
  int          sva_errors;
  int          expected_commits;
  bit          stalled;  // a word waited on inst_ready
  bit          loaded;

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  ooo_core ooo_core_inst (
    .clk_100mhz, .sys_rst, .inst_valid, .inst, .inst_ready,
    .commit_valid, .commit_rd, .commit_value
  );

  commit_checker commit_checker_inst (
    .clk_100mhz, .sys_rst, .exp_push, .exp_index, .exp_rd, .exp_value,
    .commit_valid, .commit_rd, .commit_value,
    .error_count(checker_errors), .pending, .commit_count
  );

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_word(input logic [31:0] word, input logic expects, input int index,
                           input logic [4:0] rd, input logic [31:0] value);
    logic accepted;
    inst       = word;
    inst_valid = 1'b1;
    exp_push   = expects;
    exp_index  = index;
    exp_rd     = rd;
    exp_value  = value;
    accepted   = 1'b0;
    while (!accepted) begin
      accepted = inst_ready;  // stable up to the next rising edge
      if (!accepted) stalled = 1'b1;
      @(negedge clk_100mhz);
      exp_push = 1'b0;
    end
    inst_valid = 1'b0;
  endtask

  initial begin
    int          base;
    int          gap;
    logic [31:0] rd_field;
    sys_rst          = 1'b1;
    inst_valid       = 1'b0;
    inst             = '0;
    exp_push         = 1'b0;
    exp_index        = 0;
    exp_rd           = '0;
    exp_value        = '0;
    tb_errors        = 0;
    expected_commits = 0;
    stalled          = 1'b0;
    loaded           = 1'b0;
    void'($urandom(SEED));
    $readmemh("verif/ooo_core_tests.mem", test_mem);
    n_tests = int'(test_mem[0]);
    if (n_tests < 1 || n_tests > max_tests) begin
      $display("test file verif/ooo_core_tests.mem holds a bad test count %0d", n_tests);
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (5) @(posedge clk_100mhz);
      @(negedge clk_100mhz);
      sys_rst = 1'b0;
      repeat (3) @(negedge clk_100mhz);  // idle core, checker flags any commit
      if (inst_ready !== 1'b1) begin
        tb_errors++;
        $display("inst_ready is not high after reset");
      end
      for (int i = 0; i < n_tests; i++) begin
        base     = 1 + 3 * i;
        rd_field = test_mem[base + 1];
        if (rd_field != no_commit) expected_commits++;
        send_word(test_mem[base], rd_field != no_commit, i, rd_field[4:0],
                  test_mem[base + 2]);
        gap = ($urandom % 4 == 0) ? int'(1 + $urandom % 2) : 0;  // mostly back to back
        repeat (gap) @(negedge clk_100mhz);
      end
      while (pending != 0) @(negedge clk_100mhz);
      repeat (20) @(negedge clk_100mhz);  // room for stray or duplicate commits
      if (!stalled) begin
        tb_errors++;
        $display("inst_ready never fell, the mul chain did not back up the queue");
      end
      sva_errors = ooo_core_inst.reorder_buffer_inst.ooo_core_sva_inst.assert_failures;
      $display("errors: %0d (checker %0d, testbench %0d, assertions %0d), commits %0d of %0d",
               checker_errors + tb_errors + sva_errors, checker_errors, tb_errors,
               sva_errors, commit_count, expected_commits);
      if (checker_errors + tb_errors + sva_errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // watchdog, scaled by the number of instructions
  initial begin
    int limit;
    wait (loaded);
    limit = 40 * n_tests + 200;
    repeat (limit) @(posedge clk_100mhz);
    $display("timeout after %0d cycles, %0d instructions never committed", limit, pending);
    $display("Simulation finished: FAIL");
    $finish;
  end
endmodule

/* verif/ooo_core_sva.sv */
`timescale 1ns/10ps

module ooo_core_sva #(
  parameter int ROB_SIZE = 8,
  parameter int TAG_W    = 3
) (
  input logic                clk_100mhz,
  input logic                sys_rst,
  input logic                alloc,
  input logic                commit_valid,
  input logic                cdb_valid,
  input logic [TAG_W-1:0]    cdb_tag,
  input logic [ROB_SIZE-1:0] done
);
  localparam int cnt_w = $clog2(ROB_SIZE + 1);

  logic [cnt_w-1:0] occupancy;  // entries allocated and not yet retired
  int               assert_failures = 0;  // failures seen so far

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) occupancy <= '0;
    else occupancy <= occupancy + cnt_w'(alloc) - cnt_w'(commit_valid);
  end

  commit_when_empty: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    commit_valid |-> occupancy != '0)
    else begin
      $error("ROB commit while the buffer is empty");
      assert_failures++;
    end

  alloc_when_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    alloc |-> occupancy < cnt_w'(ROB_SIZE))
    else begin
      $error("ROB allocation while the buffer is full");
      assert_failures++;
    end

  cdb_on_done_entry: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    cdb_valid |-> !done[cdb_tag])
    else begin
      $error("CDB result for ROB entry %0d that is already done", cdb_tag);
      assert_failures++;
    end
endmodule

bind reorder_buffer ooo_core_sva #(.ROB_SIZE(ROB_SIZE), .TAG_W(TAG_W)) ooo_core_sva_inst (
  .clk_100mhz, .sys_rst, .alloc, .commit_valid,
  .cdb_valid, .cdb_tag, .done
);

/* hw/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core #(
  parameter int IQ_DEPTH   = 4,
  parameter int ROB_SIZE   = 8,
  parameter int RS_SLOTS   = 2,
  parameter int MUL_STAGES = 3
) (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  output logic        inst_ready,
  output logic        commit_valid,
  output logic [4:0]  commit_rd,
  output logic [31:0] commit_value
);
  import ooo_pkg::*;

  localparam int TAG_W = tag_bits(ROB_SIZE);

  inst_word_t       iq_head;
  logic             iq_head_valid;
  logic             iq_pop;
  logic             iq_full;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [xlen-1:0]  rf_val1;
  logic [xlen-1:0]  rf_val2;
  logic [TAG_W-1:0] rf_tag1;
  logic [TAG_W-1:0] rf_tag2;
  logic             rf_busy1;
  logic             rf_busy2;
  logic             rob_free;
  logic             alloc;
  logic [4:0]       alloc_rd;
  logic [TAG_W-1:0] alloc_tag;
  logic             rename;
  logic             alu_rs_free;
  logic             mul_rs_free;
  logic             alu_disp_valid;
  alu_op_t          alu_disp_op;
  logic [xlen-1:0]  alu_disp_a;
  logic [xlen-1:0]  alu_disp_b;
  logic [TAG_W-1:0] alu_disp_tag;
  logic             alu_ready;
  logic             mul_disp_valid;
  logic [xlen-1:0]  mul_disp_a;
  logic [xlen-1:0]  mul_disp_b;
  logic [TAG_W-1:0] mul_disp_tag;
  logic             cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  logic [xlen-1:0]  cdb_value;
  logic [TAG_W-1:0] commit_tag;

  issue_if #(.TAG_W(TAG_W))      alu_issue ();
  issue_if #(.TAG_W(TAG_W))      mul_issue ();
  rob_lookup_if #(.TAG_W(TAG_W)) rob_lookup ();

  assign inst_ready = !iq_full;

  inst_queue #(.IQ_DEPTH(IQ_DEPTH)) inst_queue_inst (
    .clk_100mhz, .sys_rst,
    .push(inst_valid), .push_word(inst),
    .pop(iq_pop), .head(iq_head), .head_valid(iq_head_valid), .full(iq_full)
  );

  issue_unit #(.TAG_W(TAG_W)) issue_unit_inst (
    .head(iq_head), .head_valid(iq_head_valid), .pop(iq_pop),
    .rs1, .rs2, .rf_val1, .rf_val2, .rf_tag1, .rf_tag2, .rf_busy1, .rf_busy2,
    .rob_lookup, .rob_free, .alloc, .alloc_rd, .alloc_tag,
    .alu_issue, .mul_issue, .alu_rs_free, .mul_rs_free, .rename
  );

  register_file #(.TAG_W(TAG_W)) register_file_inst (
    .clk_100mhz, .sys_rst, .rs1, .rs2,
    .val1(rf_val1), .val2(rf_val2), .tag1(rf_tag1), .tag2(rf_tag2),
    .busy1(rf_busy1), .busy2(rf_busy2),
    .rename, .rename_rd(alloc_rd), .rename_tag(alloc_tag),
    .commit_valid, .commit_rd, .commit_tag, .commit_value
  );

  reorder_buffer #(.ROB_SIZE(ROB_SIZE), .TAG_W(TAG_W)) reorder_buffer_inst (
    .clk_100mhz, .sys_rst, .alloc, .alloc_rd, .alloc_tag, .rob_free,
    .cdb_valid, .cdb_tag, .cdb_value, .lookup(rob_lookup),
    .commit_valid, .commit_rd, .commit_tag, .commit_value
  );

  reservation_station #(.RS_SLOTS(RS_SLOTS), .TAG_W(TAG_W)) alu_rs (
    .clk_100mhz, .sys_rst, .issue(alu_issue), .rs_free(alu_rs_free),
    .cdb_valid, .cdb_tag, .cdb_value, .unit_ready(alu_ready),
    .disp_valid(alu_disp_valid), .disp_op(alu_disp_op),
    .disp_a(alu_disp_a), .disp_b(alu_disp_b), .disp_tag(alu_disp_tag)
  );

  reservation_station #(.RS_SLOTS(RS_SLOTS), .TAG_W(TAG_W)) mul_rs (
    .clk_100mhz, .sys_rst, .issue(mul_issue), .rs_free(mul_rs_free),
    .cdb_valid, .cdb_tag, .cdb_value, .unit_ready(1'b1),  // pipeline takes one per cycle
    .disp_valid(mul_disp_valid), .disp_op(),
    .disp_a(mul_disp_a), .disp_b(mul_disp_b), .disp_tag(mul_disp_tag)
  );

  execute_stage #(.MUL_STAGES(MUL_STAGES), .TAG_W(TAG_W)) execute_stage_inst (
    .clk_100mhz, .sys_rst,
    .alu_valid(alu_disp_valid), .alu_op(alu_disp_op), .alu_a(alu_disp_a),
    .alu_b(alu_disp_b), .alu_tag(alu_disp_tag), .alu_ready,
    .mul_valid(mul_disp_valid), .mul_a(mul_disp_a), .mul_b(mul_disp_b),
    .mul_tag(mul_disp_tag), .cdb_valid, .cdb_tag, .cdb_value
  );
endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage #(
  parameter int MUL_STAGES = 3,
  parameter int TAG_W      = 3
) (
  input  logic                     clk_100mhz,
  input  logic                     sys_rst,
  input  logic                     alu_valid,
  input  ooo_pkg::alu_op_t         alu_op,
  input  logic [ooo_pkg::xlen-1:0] alu_a,
  input  logic [ooo_pkg::xlen-1:0] alu_b,
  input  logic [TAG_W-1:0]         alu_tag,
  output logic                     alu_ready,
  input  logic                     mul_valid,
  input  logic [ooo_pkg::xlen-1:0] mul_a,
  input  logic [ooo_pkg::xlen-1:0] mul_b,
  input  logic [TAG_W-1:0]         mul_tag,
  output logic                     cdb_valid,
  output logic [TAG_W-1:0]         cdb_tag,
  output logic [ooo_pkg::xlen-1:0] cdb_value
);
  import ooo_pkg::*;

  logic [xlen-1:0]       alu_res;
  logic [xlen-1:0]       alu_hold;
  logic [TAG_W-1:0]      alu_hold_tag;
  logic                  alu_full;   // result waiting for the CDB
  logic                  alu_grant;
  logic [MUL_STAGES-1:0] mul_v;
  logic [xlen-1:0]       mul_p [MUL_STAGES];
  logic [TAG_W-1:0]      mul_t [MUL_STAGES];
  logic                  mul_done;

  always_comb begin
    case (alu_op)
      op_add:  alu_res = alu_a + alu_b;
      op_sub:  alu_res = alu_a - alu_b;
      op_and:  alu_res = alu_a & alu_b;
      op_or:   alu_res = alu_a | alu_b;
      op_xor:  alu_res = alu_a ^ alu_b;
      op_sll:  alu_res = alu_a << alu_b[4:0];
      op_srl:  alu_res = alu_a >> alu_b[4:0];
      op_slt:  alu_res = ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
      default: alu_res = '0;
    endcase
  end

  // multiplier never stalls, so it always owns the CDB first
  assign mul_done  = mul_v[MUL_STAGES-1];
  assign alu_grant = alu_full && !mul_done;
  assign alu_ready = !alu_full || alu_grant;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      alu_full  <= 1'b0;
      mul_v     <= '0;
      cdb_valid <= 1'b0;
    end else begin
      if (alu_valid) alu_full <= 1'b1;
      else if (alu_grant) alu_full <= 1'b0;
      mul_v[0] <= mul_valid;
      for (int i = 1; i < MUL_STAGES; i++) mul_v[i] <= mul_v[i-1];
      cdb_valid <= mul_done || alu_full;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (alu_valid) begin
      alu_hold     <= alu_res;
      alu_hold_tag <= alu_tag;
    end
    mul_p[0] <= mul_a * mul_b;  // low 32 bits of the product
    mul_t[0] <= mul_tag;
    for (int i = 1; i < MUL_STAGES; i++) begin
      mul_p[i] <= mul_p[i-1];
      mul_t[i] <= mul_t[i-1];
    end
    cdb_tag   <= mul_done ? mul_t[MUL_STAGES-1] : alu_hold_tag;
    cdb_value <= mul_done ? mul_p[MUL_STAGES-1] : alu_hold;
  end
endmodule

/* hw/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station #(
  parameter int RS_SLOTS = 2,
  parameter int TAG_W    = 3
) (
  input  logic                     clk_100mhz,
  input  logic                     sys_rst,
  issue_if.sink                    issue,
  output logic                     rs_free,
  input  logic                     cdb_valid,
  input  logic [TAG_W-1:0]         cdb_tag,
  input  logic [ooo_pkg::xlen-1:0] cdb_value,
  input  logic                     unit_ready,
  output logic                     disp_valid,
  output ooo_pkg::alu_op_t         disp_op,
  output logic [ooo_pkg::xlen-1:0] disp_a,
  output logic [ooo_pkg::xlen-1:0] disp_b,
  output logic [TAG_W-1:0]         disp_tag
);
  import ooo_pkg::*;

  localparam int ix_w = (RS_SLOTS > 1) ? $clog2(RS_SLOTS) : 1;

  logic [RS_SLOTS-1:0] busy;
  logic [RS_SLOTS-1:0] ri;
  logic [RS_SLOTS-1:0] rj;
  logic [RS_SLOTS-1:0] hit_i;
  logic [RS_SLOTS-1:0] hit_j;
  alu_op_t             op [RS_SLOTS];
  logic [xlen-1:0]     vi [RS_SLOTS];
  logic [xlen-1:0]     vj [RS_SLOTS];
  logic [TAG_W-1:0]    qi [RS_SLOTS];
  logic [TAG_W-1:0]    qj [RS_SLOTS];
  logic [TAG_W-1:0]    tag [RS_SLOTS];
  logic [ix_w-1:0]     age [RS_SLOTS];  // count of younger entries
  logic [ix_w-1:0]     sel;
  logic [ix_w-1:0]     free_ix;
  logic                found;
  logic                cap_i;
  logic                cap_j;

  always_comb begin
    found   = 1'b0;
    sel     = '0;
    free_ix = '0;
    rs_free = 1'b0;
    for (int i = 0; i < RS_SLOTS; i++) begin
      hit_i[i] = cdb_valid && (cdb_tag == qi[i]);
      hit_j[i] = cdb_valid && (cdb_tag == qj[i]);
      if (!busy[i] && !rs_free) begin
        rs_free = 1'b1;
        free_ix = ix_w'(i);
      end
      // ready now, counting a CDB value arriving this cycle
      if (busy[i] && (ri[i] || hit_i[i]) && (rj[i] || hit_j[i])
          && (!found || age[i] > age[sel])) begin
        found = 1'b1;
        sel   = ix_w'(i);
      end
    end
  end

  assign disp_valid = found && unit_ready;
  assign disp_op    = op[sel];
  assign disp_a     = ri[sel] ? vi[sel] : cdb_value;
  assign disp_b     = rj[sel] ? vj[sel] : cdb_value;
  assign disp_tag   = tag[sel];

  assign cap_i = !issue.ri && cdb_valid && (cdb_tag == issue.qi);  // result on CDB at issue
  assign cap_j = !issue.rj && cdb_valid && (cdb_tag == issue.qj);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
    end else begin
      for (int i = 0; i < RS_SLOTS; i++) begin
        if (issue.valid && free_ix == ix_w'(i)) busy[i] <= 1'b1;
        else if (disp_valid && sel == ix_w'(i)) busy[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < RS_SLOTS; i++) begin
      if (issue.valid && free_ix == ix_w'(i)) begin
        op[i]  <= issue.op;
        vi[i]  <= cap_i ? cdb_value : issue.vi;
        vj[i]  <= cap_j ? cdb_value : issue.vj;
        qi[i]  <= issue.qi;
        qj[i]  <= issue.qj;
        ri[i]  <= issue.ri || cap_i;
        rj[i]  <= issue.rj || cap_j;
        tag[i] <= issue.rob_ix;
        age[i] <= '0;
      end else if (busy[i]) begin
        if (hit_i[i] && !ri[i]) begin
          vi[i] <= cdb_value;
          ri[i] <= 1'b1;
        end
        if (hit_j[i] && !rj[i]) begin
          vj[i] <= cdb_value;
          rj[i] <= 1'b1;
        end
        age[i] <= age[i] + ix_w'(issue.valid) - ix_w'(disp_valid && age[sel] < age[i]);
      end
    end
  end
endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer #(
  parameter int ROB_SIZE = 8,
  parameter int TAG_W    = 3
) (
  input  logic                     clk_100mhz,
  input  logic                     sys_rst,
  input  logic                     alloc,
  input  logic [4:0]               alloc_rd,
  output logic [TAG_W-1:0]         alloc_tag,
  output logic                     rob_free,
  input  logic                     cdb_valid,
  input  logic [TAG_W-1:0]         cdb_tag,
  input  logic [ooo_pkg::xlen-1:0] cdb_value,
  rob_lookup_if.resp               lookup,
  output logic                     commit_valid,
  output logic [4:0]               commit_rd,
  output logic [TAG_W-1:0]         commit_tag,
  output logic [ooo_pkg::xlen-1:0] commit_value
);
  import ooo_pkg::*;

  localparam int cnt_w = $clog2(ROB_SIZE + 1);

  logic [4:0]          rd_q [ROB_SIZE];
  logic [xlen-1:0]     value_q [ROB_SIZE];
  logic [ROB_SIZE-1:0] done;
  logic [TAG_W-1:0]    head;
  logic [TAG_W-1:0]    tail;
  logic [cnt_w-1:0]    count;

  function automatic logic [TAG_W-1:0] wrap_inc(input logic [TAG_W-1:0] p);
    return (p == TAG_W'(ROB_SIZE - 1)) ? '0 : p + 1'b1;
  endfunction

  assign alloc_tag    = tail;
  assign rob_free     = (count != cnt_w'(ROB_SIZE));
  assign commit_valid = (count != '0) && done[head];  // in-order retire
  assign commit_rd    = rd_q[head];
  assign commit_tag   = head;
  assign commit_value = value_q[head];

  // operand lookup for issue
  assign lookup.value1 = value_q[lookup.tag1];
  assign lookup.done1  = done[lookup.tag1];
  assign lookup.value2 = value_q[lookup.tag2];
  assign lookup.done2  = done[lookup.tag2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc) begin
        done[tail] <= 1'b0;
        tail       <= wrap_inc(tail);
      end
      if (cdb_valid) done[cdb_tag] <= 1'b1;
      if (commit_valid) head <= wrap_inc(head);
      count <= count + cnt_w'(alloc) - cnt_w'(commit_valid);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (alloc) rd_q[tail] <= alloc_rd;
    if (cdb_valid) value_q[cdb_tag] <= cdb_value;
  end
endmodule

/* hw/register_file.sv */
`timescale 1ns/10ps

module register_file #(
  parameter int TAG_W = 3
) (
  input  logic                     clk_100mhz,
  input  logic                     sys_rst,
  input  logic [4:0]               rs1,
  input  logic [4:0]               rs2,
  output logic [ooo_pkg::xlen-1:0] val1,
  output logic [ooo_pkg::xlen-1:0] val2,
  output logic [TAG_W-1:0]         tag1,
  output logic [TAG_W-1:0]         tag2,
  output logic                     busy1,
  output logic                     busy2,
  input  logic                     rename,
  input  logic [4:0]               rename_rd,
  input  logic [TAG_W-1:0]         rename_tag,
  input  logic                     commit_valid,
  input  logic [4:0]               commit_rd,
  input  logic [TAG_W-1:0]         commit_tag,
  input  logic [ooo_pkg::xlen-1:0] commit_value
);
  import ooo_pkg::*;

  logic [xlen-1:0]  regs [32];
  logic [TAG_W-1:0] tags [32];
  logic [31:0]      busy;  // register waits on ROB entry tags[n]

  assign val1  = regs[rs1];  // x0 is never written, reads zero
  assign val2  = regs[rs2];
  assign tag1  = tags[rs1];
  assign tag2  = tags[rs2];
  assign busy1 = busy[rs1];
  assign busy2 = busy[rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      if (commit_valid && commit_rd != 5'd0) begin
        regs[commit_rd] <= commit_value;
        if (tags[commit_rd] == commit_tag) busy[commit_rd] <= 1'b0;  // no newer rename
      end
      if (rename && rename_rd != 5'd0) busy[rename_rd] <= 1'b1;  // wins over commit
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (rename && rename_rd != 5'd0) tags[rename_rd] <= rename_tag;
  end
endmodule

/* hw/issue_unit.sv */
`timescale 1ns/10ps

module issue_unit #(
  parameter int TAG_W = 3
) (
  input  ooo_pkg::inst_word_t       head,
  input  logic                      head_valid,
  output logic                      pop,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  input  logic [ooo_pkg::xlen-1:0]  rf_val1,
  input  logic [ooo_pkg::xlen-1:0]  rf_val2,
  input  logic [TAG_W-1:0]          rf_tag1,
  input  logic [TAG_W-1:0]          rf_tag2,
  input  logic                      rf_busy1,
  input  logic                      rf_busy2,
  rob_lookup_if.req                 rob_lookup,
  input  logic                      rob_free,
  output logic                      alloc,
  output logic [4:0]                alloc_rd,
  input  logic [TAG_W-1:0]          alloc_tag,
  issue_if.src                      alu_issue,
  issue_if.src                      mul_issue,
  input  logic                      alu_rs_free,
  input  logic                      mul_rs_free,
  output logic                      rename
);
  import ooo_pkg::*;

  op_kind_t         kind;
  alu_op_t          op;
  logic [xlen-1:0]  imm;
  logic [xlen-1:0]  vi;
  logic [xlen-1:0]  vj;
  logic [TAG_W-1:0] qi;
  logic [TAG_W-1:0] qj;
  logic             ri;
  logic             rj;
  logic             unit_free;
  logic             do_issue;

  assign rs1      = head.r_fields.rs1;
  assign rs2      = head.r_fields.rs2;
  assign alloc_rd = head.r_fields.rd;
  assign imm      = {{(xlen - 12){head.i_fields.imm12[11]}}, head.i_fields.imm12};

  always_comb begin
    kind = kind_nop;
    op   = op_add;
    if (head.r_fields.opcode == opc_op) begin
      kind = kind_alu;
      case ({head.r_fields.funct7, head.r_fields.funct3})
        10'b0000000_000: op = op_add;
        10'b0100000_000: op = op_sub;
        10'b0000000_001: op = op_sll;
        10'b0000000_010: op = op_slt;
        10'b0000000_100: op = op_xor;
        10'b0000000_101: op = op_srl;
        10'b0000000_110: op = op_or;
        10'b0000000_111: op = op_and;
        10'b0000001_000: kind = kind_mul;
        default:         kind = kind_nop;  // sra, sltu, rest of M
      endcase
    end else if (head.i_fields.opcode == opc_opimm) begin
      kind = kind_alu;
      case (head.i_fields.funct3)
        3'b000:  op = op_add;
        3'b010:  op = op_slt;
        3'b100:  op = op_xor;
        3'b110:  op = op_or;
        3'b111:  op = op_and;
        default: kind = kind_nop;  // shifts by immediate, sltiu
      endcase
    end
  end

  assign rob_lookup.tag1 = rf_tag1;
  assign rob_lookup.tag2 = rf_tag2;

  // operand source: register file, then finished ROB entry, else wait on tag
  always_comb begin
    vi = rf_busy1 ? rob_lookup.value1 : rf_val1;
    ri = !rf_busy1 || rob_lookup.done1;
    qi = rf_tag1;
    vj = rf_busy2 ? rob_lookup.value2 : rf_val2;
    rj = !rf_busy2 || rob_lookup.done2;
    qj = rf_tag2;
    if (head.i_fields.opcode == opc_opimm) begin
      vj = imm;
      rj = 1'b1;
    end
  end

  assign unit_free = (kind == kind_mul) ? mul_rs_free : alu_rs_free;
  assign do_issue  = head_valid && (kind != kind_nop) && rob_free && unit_free;
  assign pop       = do_issue || (head_valid && kind == kind_nop);
  assign alloc     = do_issue;
  assign rename    = do_issue && (alloc_rd != 5'd0);

  assign alu_issue.valid  = do_issue && (kind == kind_alu);
  assign alu_issue.op     = op;
  assign alu_issue.vi     = vi;
  assign alu_issue.vj     = vj;
  assign alu_issue.qi     = qi;
  assign alu_issue.qj     = qj;
  assign alu_issue.ri     = ri;
  assign alu_issue.rj     = rj;
  assign alu_issue.rob_ix = alloc_tag;

  assign mul_issue.valid  = do_issue && (kind == kind_mul);
  assign mul_issue.op     = op;
  assign mul_issue.vi     = vi;
  assign mul_issue.vj     = vj;
  assign mul_issue.qi     = qi;
  assign mul_issue.qj     = qj;
  assign mul_issue.ri     = ri;
  assign mul_issue.rj     = rj;
  assign mul_issue.rob_ix = alloc_tag;
endmodule

/* hw/inst_queue.sv */
`timescale 1ns/10ps

module inst_queue #(
  parameter int IQ_DEPTH = 4
) (
  input  logic                clk_100mhz,
  input  logic                sys_rst,
  input  logic                push,
  input  ooo_pkg::inst_word_t push_word,
  input  logic                pop,
  output ooo_pkg::inst_word_t head,
  output logic                head_valid,
  output logic                full
);
  import ooo_pkg::*;

  localparam int ptr_w = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int cnt_w = $clog2(IQ_DEPTH + 1);

  inst_word_t       mem [IQ_DEPTH];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == cnt_w'(IQ_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign do_push    = push && !full;  // full word is held upstream
  assign do_pop     = pop && head_valid;

  always_ff @(posedge clk_100mhz) begin
    if (do_push) mem[wr_ptr] <= push_word;
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_w'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end
endmodule

/* hw/issue_if.sv */
`timescale 1ns/10ps

interface issue_if #(
  parameter int TAG_W = $bits(ooo_pkg::rob_tag_t)
);
  import ooo_pkg::*;

  logic             valid;
  alu_op_t          op;
  logic [xlen-1:0]  vi;
  logic [xlen-1:0]  vj;
  logic [TAG_W-1:0] qi;
  logic [TAG_W-1:0] qj;
  logic             ri;      // vi present
  logic             rj;      // vj present
  logic [TAG_W-1:0] rob_ix;

  modport src  (output valid, op, vi, vj, qi, qj, ri, rj, rob_ix);
  modport sink (input valid, op, vi, vj, qi, qj, ri, rj, rob_ix);
endinterface

interface rob_lookup_if #(
  parameter int TAG_W = $bits(ooo_pkg::rob_tag_t)
);
  import ooo_pkg::*;

  logic [TAG_W-1:0] tag1;
  logic [TAG_W-1:0] tag2;
  logic [xlen-1:0]  value1;
  logic [xlen-1:0]  value2;
  logic             done1;
  logic             done2;

  modport req  (output tag1, tag2, input value1, value2, done1, done2);
  modport resp (input tag1, tag2, output value1, value2, done1, done2);
endinterface

/* hw/ooo_pkg.sv */
package ooo_pkg;

  localparam int xlen = 32;

  localparam logic [6:0] opc_op    = 7'b0110011;
  localparam logic [6:0] opc_opimm = 7'b0010011;

  typedef logic [2:0] rob_tag_t;  // fits the default 8-entry ROB

  typedef enum logic [1:0] {
    kind_nop,
    kind_alu,
    kind_mul
  } op_kind_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // one instruction word, read as R-type or I-type
  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } inst_word_t;

  function automatic int tag_bits(input int size);
    return (size > 1) ? $clog2(size) : 1;
  endfunction

endpackage
